// File: verilog/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// pc and read data beat width
`define FETCH_XLEN 64

// read channel address width
`define FETCH_ADDR_W 32

// fetch queue entries, power of two and at least 2
`define FQ_DEPTH 4

// instruction word width, no compressed support
`define FETCH_ILEN 32

`endif

// File: verilog/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

   // register-register layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   // immediate, loads, jalr, system
   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // stores, immediate split around rs fields
   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
   } s_fmt_t;

   // conditional branches, bit 0 of offset implied
   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   // lui and auipc
   typedef struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   // jal, scrambled 21 bit offset
   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   // one instruction word, six ways to read it
   typedef union packed {
      logic [`FETCH_ILEN-1:0] raw;
      r_fmt_t                 r_fmt;
      i_fmt_t                 i_fmt;
      s_fmt_t                 s_fmt;
      b_fmt_t                 b_fmt;
      u_fmt_t                 u_fmt;
      j_fmt_t                 j_fmt;
   } inst_word_u;

   // read data beat as seen on the r channel
   typedef struct packed {
      logic [`FETCH_XLEN-1:0] data;
      logic                   resp;
   } mem_rsp_t;

   // entry passed from fetch to decode through the queue
   typedef struct packed {
      logic [`FETCH_XLEN-1:0] pc;
      inst_word_u             inst;
      logic                   fault;
   } fetch_pkt_t;

   typedef enum logic [3:0] {
      k_alu_reg,
      k_alu_imm,
      k_load,
      k_store,
      k_branch,
      k_jal,
      k_jalr,
      k_lui,
      k_auipc,
      k_system,
      k_illegal,
      k_fault
   } inst_kind_e;

   // decoded record, unused fields read as zero
   typedef struct packed {
      logic [`FETCH_XLEN-1:0] pc;
      inst_kind_e             kind;
      logic [4:0]             rd;
      logic [4:0]             rs1;
      logic [4:0]             rs2;
      logic [`FETCH_XLEN-1:0] imm;
   } dec_rec_t;

endpackage

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit (
   input  logic                     clk,
   input  logic                     rst_n,
   // read address channel
   output logic                     ar_valid,
   output logic [`FETCH_ADDR_W-1:0] ar_addr,
   input  logic                     ar_ready,
   // read data channel
   input  logic                     r_valid,
   input  fetch_pkg::mem_rsp_t      r_rsp,
   output logic                     r_ready,
   // toward the fetch queue
   output logic                     push,
   output fetch_pkg::fetch_pkt_t    push_pkt,
   input  logic                     full,
   // jal redirect from decode
   input  logic                     redirect,
   input  logic [`FETCH_XLEN-1:0]   redirect_pc
);

   localparam int XLEN   = `FETCH_XLEN;
   localparam int ADDR_W = `FETCH_ADDR_W;
   localparam int HALF   = XLEN / 2;

   // address of the next word to fetch
   logic [XLEN-1:0] pc;
   // request accepted, beat not yet seen
   logic            outstanding;
   // in-flight request belongs to a squashed path
   logic            stale;

   logic busy;
   logic issue;
   logic ar_acc;
   logic beat;

   // one word in flight at a time, counting the push cycle
   assign busy   = ar_valid | outstanding | push;

   // no issue in a redirect cycle, pc is about to change
   assign issue  = !busy && !full && !redirect;

   assign ar_acc = ar_valid && ar_ready;

   // ready only while waiting for our single response
   assign r_ready = outstanding;

   assign beat   = r_valid && r_ready;

   // request handshake and response tracking
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ar_valid    <= 1'b0;
         outstanding <= 1'b0;
         push        <= 1'b0;
      end else begin
         push <= 1'b0;
         if (ar_acc) begin
            ar_valid    <= 1'b0;
            outstanding <= 1'b1;
         end else if (issue) begin
            ar_valid <= 1'b1;
         end
         if (beat) begin
            outstanding <= 1'b0;
            // squashed words are taken off the bus but never queued
            push        <= !(stale || redirect);
         end
      end
   end

   // stale marking across a redirect
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stale <= 1'b0;
      end else if (beat) begin
         stale <= 1'b0;
      end else if (redirect && (ar_valid || outstanding)) begin
         // address may still be waiting on ar_ready
         stale <= 1'b1;
      end
   end

   // program counter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= `FETCH_RESET_PC;
      end else if (redirect) begin
         // jal target beats the sequential step
         pc <= redirect_pc;
      end else if (push) begin
         pc <= pc + XLEN'(4);
      end
   end

   // request address, held from issue until the beat is back
   always_ff @(posedge clk) begin
      if (issue) begin
         ar_addr <= pc[ADDR_W-1:0];
      end
   end

   // packet for the queue
   always_ff @(posedge clk) begin
      if (beat) begin
         // pc is unchanged since issue unless the word is stale
         push_pkt.pc <= pc;
         // bit 2 picks which half of the beat holds the word
         if (ar_addr[2]) begin
            push_pkt.inst.raw <= r_rsp.data[XLEN-1:HALF];
         end else begin
            push_pkt.inst.raw <= r_rsp.data[HALF-1:0];
         end
         push_pkt.fault <= r_rsp.resp;
      end
   end

endmodule

`default_nettype wire

// File: verilog/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_queue (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  push,
   input  fetch_pkg::fetch_pkt_t push_pkt,
   input  logic                  pop,
   input  logic                  flush,
   output fetch_pkg::fetch_pkt_t head,
   output logic                  not_empty,
   output logic                  full
);

   import fetch_pkg::*;

   localparam int DEPTH = `FQ_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = PTR_W + 1;

   // packet storage
   fetch_pkt_t mem [DEPTH];

   // pointers wrap on their own, depth is a power of two
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   logic do_push;
   logic do_pop;

   assign full      = (count == CNT_W'(DEPTH));
   assign not_empty = (count != '0);

   // flush drops anything arriving in the same cycle
   assign do_push = push && !full && !flush;
   assign do_pop  = pop && not_empty && !flush;

   // oldest entry shown without a read cycle
   assign head = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         // whole queue emptied in one cycle
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            // both or neither leaves the level alone
            default: count <= count;
         endcase
      end
   end

   // storage write
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_pkt;
      end
   end

endmodule

`default_nettype wire

// File: verilog/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module inst_decode (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   not_empty,
   input  fetch_pkg::fetch_pkt_t  head,
   output logic                   pop,
   output logic                   dec_valid,
   output fetch_pkg::dec_rec_t    dec,
   output logic                   redirect,
   output logic [`FETCH_XLEN-1:0] redirect_pc
);

   import fetch_pkg::*;

   localparam int XLEN = `FETCH_XLEN;

   // base opcodes, rv64i
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_IMM32  = 7'b0011011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_REG32  = 7'b0111011;
   localparam logic [6:0] OP_SYSTEM = 7'b1110011;

   inst_word_u      iw;
   dec_rec_t        rec_next;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_s;
   logic [XLEN-1:0] imm_b;
   logic [XLEN-1:0] imm_u;
   logic [XLEN-1:0] imm_j;

   assign iw = head.inst;

   // sign-extended immediates, one per layout
   assign imm_i = {{(XLEN-12){iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
   assign imm_s = {{(XLEN-12){iw.s_fmt.imm_11_5[6]}}, iw.s_fmt.imm_11_5, iw.s_fmt.imm_4_0};
   assign imm_b = {{(XLEN-13){iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                   iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
   assign imm_u = {{(XLEN-32){iw.u_fmt.imm_31_12[19]}}, iw.u_fmt.imm_31_12, 12'b0};
   assign imm_j = {{(XLEN-21){iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                   iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};

   // take a word whenever one waits, except while redirecting
   assign pop = not_empty && !redirect;

   // classify and pick fields
   always_comb begin
      rec_next      = '0;
      rec_next.pc   = head.pc;
      rec_next.kind = k_illegal;
      if (head.fault) begin
         // bus error carries only its pc
         rec_next.kind = k_fault;
      end else begin
         case (iw.r_fmt.opcode)
            OP_LUI, OP_AUIPC: begin
               rec_next.kind = (iw.r_fmt.opcode == OP_LUI) ? k_lui : k_auipc;
               rec_next.rd   = iw.u_fmt.rd;
               rec_next.imm  = imm_u;
            end
            OP_JAL: begin
               rec_next.kind = k_jal;
               rec_next.rd   = iw.j_fmt.rd;
               rec_next.imm  = imm_j;
            end
            OP_JALR, OP_LOAD, OP_IMM, OP_IMM32, OP_SYSTEM: begin
               case (iw.r_fmt.opcode)
                  OP_JALR:   rec_next.kind = k_jalr;
                  OP_LOAD:   rec_next.kind = k_load;
                  OP_SYSTEM: rec_next.kind = k_system;
                  default:   rec_next.kind = k_alu_imm;
               endcase
               rec_next.rd  = iw.i_fmt.rd;
               rec_next.rs1 = iw.i_fmt.rs1;
               rec_next.imm = imm_i;
            end
            OP_STORE: begin
               rec_next.kind = k_store;
               rec_next.rs1  = iw.s_fmt.rs1;
               rec_next.rs2  = iw.s_fmt.rs2;
               rec_next.imm  = imm_s;
            end
            OP_BRANCH: begin
               // classified only, fetch falls through
               rec_next.kind = k_branch;
               rec_next.rs1  = iw.b_fmt.rs1;
               rec_next.rs2  = iw.b_fmt.rs2;
               rec_next.imm  = imm_b;
            end
            OP_REG, OP_REG32: begin
               rec_next.kind = k_alu_reg;
               rec_next.rd   = iw.r_fmt.rd;
               rec_next.rs1  = iw.r_fmt.rs1;
               rec_next.rs2  = iw.r_fmt.rs2;
            end
            default: begin
               rec_next.kind = k_illegal;
            end
         endcase
      end
   end

   // strobes, one cycle after the pop
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dec_valid <= 1'b0;
         redirect  <= 1'b0;
      end else begin
         dec_valid <= pop;
         redirect  <= pop && (rec_next.kind == k_jal);
      end
   end

   // record and jal target
   always_ff @(posedge clk) begin
      if (pop) begin
         dec         <= rec_next;
         redirect_pc <= head.pc + imm_j;
      end
   end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top (
   input  logic                     clk,
   input  logic                     rst_n,
   // instruction memory read channel
   output logic                     ar_valid,
   output logic [`FETCH_ADDR_W-1:0] ar_addr,
   input  logic                     ar_ready,
   input  logic                     r_valid,
   input  fetch_pkg::mem_rsp_t      r_rsp,
   output logic                     r_ready,
   // decoded stream out
   output logic                     dec_valid,
   output fetch_pkg::dec_rec_t      dec
);

   import fetch_pkg::*;

   // fetch to queue
   logic       push;
   fetch_pkt_t push_pkt;
   logic       full;

   // queue to decode
   logic       not_empty;
   fetch_pkt_t head;
   logic       pop;

   // jal redirect, also flushes the queue
   logic                   redirect;
   logic [`FETCH_XLEN-1:0] redirect_pc;

   fetch_unit u_fetch_unit (
      .clk         (clk),
      .rst_n       (rst_n),
      .ar_valid    (ar_valid),
      .ar_addr     (ar_addr),
      .ar_ready    (ar_ready),
      .r_valid     (r_valid),
      .r_rsp       (r_rsp),
      .r_ready     (r_ready),
      .push        (push),
      .push_pkt    (push_pkt),
      .full        (full),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   fetch_queue u_fetch_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_pkt  (push_pkt),
      .pop       (pop),
      .flush     (redirect),
      .head      (head),
      .not_empty (not_empty),
      .full      (full)
   );

   inst_decode u_inst_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .not_empty   (not_empty),
      .head        (head),
      .pop         (pop),
      .dec_valid   (dec_valid),
      .dec         (dec),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

endmodule

`default_nettype wire

// File: bench/fetch_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top_chk (
   input logic                         clk,
   input logic                         rst_n,
   input logic                         ar_valid,
   input logic [`FETCH_ADDR_W-1:0]     ar_addr,
   input logic                         ar_ready,
   input logic                         r_valid,
   input logic                         r_ready,
   input logic [$clog2(`FQ_DEPTH)-1:0] q_rd_ptr,
   input logic                         dec_valid
);

   // property failures so far
   int unsigned err_count = 0;

   // requests accepted minus beats returned
   logic [1:0] in_flight;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_flight <= '0;
      end else begin
         case ({ar_valid && ar_ready, r_valid && r_ready})
            2'b10:   in_flight <= in_flight + 2'd1;
            2'b01:   in_flight <= in_flight - 2'd1;
            default: in_flight <= in_flight;
         endcase
      end
   end

   // request held until the memory takes it
   a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)))
      else begin
         $error("ar_valid or ar_addr changed before ar_ready");
         err_count++;
      end

   // new address only once the last beat is back
   a_one_out: assert property (@(posedge clk) disable iff (!rst_n)
      (ar_valid && ar_ready) |-> (in_flight == 2'd0))
      else begin
         $error("second request accepted with one still outstanding");
         err_count++;
      end

   // channel quiet on the first cycle out of reset
   a_reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> (!r_ready && !ar_valid))
      else begin
         $error("read channel active right after reset");
         err_count++;
      end

   // every record took one queue entry a cycle earlier
   a_dec_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
      dec_valid |-> (q_rd_ptr == $past(q_rd_ptr) + 1'b1))
      else begin
         $error("dec_valid without a queue entry taken in the previous cycle");
         err_count++;
      end

endmodule

bind fetch_top fetch_top_chk u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .ar_valid  (ar_valid),
   .ar_addr   (ar_addr),
   .ar_ready  (ar_ready),
   .r_valid   (r_valid),
   .r_ready   (r_ready),
   .q_rd_ptr  (u_fetch_queue.rd_ptr),
   .dec_valid (dec_valid)
);

`default_nettype wire

// File: bench/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch_top;

   import fetch_pkg::*;

   localparam int                       WAIT_MAX  = 200;
   localparam int                       IMG_BEATS = 64;
   localparam int                       SEED      = 4696;
   // image base, also the first fetch address out of reset
   localparam logic [`FETCH_ADDR_W-1:0] IMG_BASE  = 32'h8000_0000;

   logic                     clk;
   logic                     rst_n;
   logic                     ar_valid;
   logic [`FETCH_ADDR_W-1:0] ar_addr;
   logic                     ar_ready;
   logic                     r_valid;
   mem_rsp_t                 r_rsp;
   logic                     r_ready;
   logic                     dec_valid;
   dec_rec_t                 dec;

   // instruction memory, one 64 bit beat per entry
   logic [`FETCH_XLEN-1:0] img_data [IMG_BEATS];
   logic                   img_ok   [IMG_BEATS];

   // expected records in trace order
   dec_rec_t exp_q [$];

   // memory model state
   logic                     ar_fire;
   logic                     r_fire;
   logic                     ar_seen;
   logic [`FETCH_ADDR_W-1:0] fire_addr;
   logic                     rsp_pend;
   mem_rsp_t                 rsp_next;
   int                       ar_wait;
   int                       r_wait;
   logic                     first_ar;
   logic                     beat_seen;
   int                       rng_init;

   fetch_top u_fetch_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .ar_valid  (ar_valid),
      .ar_addr   (ar_addr),
      .ar_ready  (ar_ready),
      .r_valid   (r_valid),
      .r_rsp     (r_rsp),
      .r_ready   (r_ready),
      .dec_valid (dec_valid),
      .dec       (dec)
   );

   // 4 ns period
   always #2 clk = ~clk;

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      stop_on_error($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_dec(input dec_rec_t got, input dec_rec_t exp);
      if (got.pc !== exp.pc) report_mismatch("dec.pc", got.pc, exp.pc);
      if (got.kind !== exp.kind) report_mismatch("dec.kind", got.kind, exp.kind);
      if (got.rd !== exp.rd) report_mismatch("dec.rd", got.rd, exp.rd);
      if (got.rs1 !== exp.rs1) report_mismatch("dec.rs1", got.rs1, exp.rs1);
      if (got.rs2 !== exp.rs2) report_mismatch("dec.rs2", got.rs2, exp.rs2);
      if (got.imm !== exp.imm) report_mismatch("dec.imm", got.imm, exp.imm);
   endtask

   task automatic check_addr(input logic [`FETCH_ADDR_W-1:0] got,
                             input logic [`FETCH_ADDR_W-1:0] exp);
      if (got !== exp) report_mismatch("ar_addr", got, exp);
   endtask

   // beat lookup, holes answer with an error
   function automatic mem_rsp_t read_beat(input logic [`FETCH_ADDR_W-1:0] addr);
      logic [`FETCH_ADDR_W-1:0] off;
      mem_rsp_t                 rsp;
      off      = addr - IMG_BASE;
      // filler built from the whole address
      rsp.data = {addr ^ 32'hdead_0000, ~addr};
      rsp.resp = 1'b1;
      if (off < IMG_BEATS * 8) begin
         if (img_ok[off[8:3]]) begin
            rsp.data = img_data[off[8:3]];
            rsp.resp = 1'b0;
         end
      end
      return rsp;
   endfunction

   task automatic load_golden();
      int               fd;
      int               n;
      logic [63:0]      tag;
      logic [8*160-1:0] rest;
      logic [63:0]      a;
      logic [63:0]      d;
      logic [63:0]      k;
      logic [63:0]      rd;
      logic [63:0]      rs1;
      logic [63:0]      rs2;
      logic [63:0]      imm;
      logic [63:0]      off;
      dec_rec_t         rec;
      foreach (img_ok[i]) img_ok[i] = 1'b0;
      fd = $fopen("bench/fetch_golden.txt", "r");
      if (fd == 0) stop_on_error("cannot open bench/fetch_golden.txt");
      while ($fscanf(fd, "%s", tag) == 1) begin
         if (tag == "#") begin
            n = $fgets(rest, fd);
         end else if (tag == "M") begin
            n   = $fscanf(fd, "%h %h", a, d);
            off = a - {32'h0, IMG_BASE};
            if (n != 2 || off >= IMG_BEATS * 8 || a[2:0] != 3'b000) begin
               stop_on_error("malformed memory line in the golden file");
            end
            img_data[off[8:3]] = d;
            img_ok[off[8:3]]   = 1'b1;
         end else if (tag == "E") begin
            n = $fscanf(fd, "%h %h %h %h %h %h", a, k, rd, rs1, rs2, imm);
            if (n != 6) stop_on_error("malformed expected record in the golden file");
            rec      = '0;
            rec.pc   = a;
            rec.kind = inst_kind_e'(k[3:0]);
            rec.rd   = rd[4:0];
            rec.rs1  = rs1[4:0];
            rec.rs2  = rs2[4:0];
            rec.imm  = imm;
            exp_q.push_back(rec);
         end else begin
            stop_on_error("unknown line tag in the golden file");
         end
      end
      $fclose(fd);
      if (exp_q.size() == 0) stop_on_error("golden file holds no expected records");
   endtask

   // next dec_valid strobe, sampled mid-cycle
   task automatic wait_dec();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!dec_valid) begin
         cycles++;
         if (cycles > WAIT_MAX) stop_on_error("no decoded record within 200 cycles");
         @(negedge clk);
      end
   endtask

   // memory model, handshakes seen mid-cycle, answered 1 ns after the edge
   always begin
      @(negedge clk);
      ar_fire   = rst_n && ar_valid && ar_ready;
      r_fire    = rst_n && r_valid && r_ready;
      ar_seen   = rst_n && ar_valid;
      fire_addr = ar_addr;
      @(posedge clk);
      #1;
      if (r_fire) r_valid = 1'b0;
      if (ar_fire) begin
         if (first_ar) check_addr(fire_addr, IMG_BASE);
         first_ar = 1'b0;
         ar_ready = 1'b0;
         ar_wait  = -1;
         rsp_next = read_beat(fire_addr);
         rsp_pend = 1'b1;
         r_wait   = $urandom % 4;
      end else if (ar_seen) begin
         // 0 to 3 cycles before the address is taken
         if (ar_wait < 0) ar_wait = $urandom % 4;
         if (ar_wait == 0) ar_ready = 1'b1;
         else ar_wait--;
      end
      if (rsp_pend && !r_valid) begin
         if (r_wait == 0) begin
            r_rsp    = rsp_next;
            r_valid  = 1'b1;
            rsp_pend = 1'b0;
         end else begin
            r_wait--;
         end
      end
   end

   // records only after data has come back, and the checker stays clean
   always @(negedge clk) begin
      if (rst_n && r_valid && r_ready) beat_seen = 1'b1;
      if (rst_n && dec_valid && !beat_seen) begin
         stop_on_error("a decoded record appeared before any read data returned");
      end
      if (u_fetch_top.u_chk.err_count != 0) stop_on_error("a bound protocol assertion failed");
   end

   initial begin
      rng_init  = $urandom(SEED);
      clk       = 1'b0;
      rst_n     = 1'b0;
      ar_ready  = 1'b0;
      r_valid   = 1'b0;
      r_rsp     = '0;
      rsp_pend  = 1'b0;
      rsp_next  = '0;
      ar_wait   = -1;
      r_wait    = 0;
      first_ar  = 1'b1;
      beat_seen = 1'b0;
      load_golden();
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // golden trace, strictly in order
      while (exp_q.size() != 0) begin
         wait_dec();
         check_dec(dec, exp_q.pop_front());
      end
      if (u_fetch_top.u_chk.err_count == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         stop_on_error("the bound checker reported a protocol error");
      end
   end

endmodule

`default_nettype wire

// File: fetch_top.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_unit.sv
verilog/fetch_queue.sv
verilog/inst_decode.sv
verilog/fetch_top.sv
bench/fetch_top_chk.sv
bench/tb_fetch_top.sv

// File: bench/fetch_golden.txt
# M <beat address> <64 bit beat, word at address+4 in the upper half>
# E <pc> <kind> <rd> <rs1> <rs2> <imm>, kind 0 alu_reg 1 alu_imm 2 load 3 store 4 branch
# 5 jal 6 jalr 7 lui 8 auipc 9 system a illegal b fault
M 80000000 12345137fff00093
M 80000008 fe208ee3fe113c23
M 80000010 010082e7002081b3
M 80000018 000000730100006f
M 80000020 0010039300000073
M 80000028 0000000bff01b203
M 80000030 00311463fffff317
M 80000038 001003930c8000ef
E 80000000 1 01 00 00 ffffffffffffffff
E 80000004 7 02 00 00 0000000012345000
E 80000008 3 00 02 01 fffffffffffffff8
E 8000000c 4 00 01 02 fffffffffffffffc
E 80000010 0 03 01 02 0000000000000000
E 80000014 6 05 01 00 0000000000000010
E 80000018 5 00 00 00 0000000000000010
E 80000028 2 04 03 00 fffffffffffffff0
E 8000002c a 00 00 00 0000000000000000
E 80000030 8 06 00 00 fffffffffffff000
E 80000034 4 00 02 03 0000000000000008
E 80000038 5 01 00 00 00000000000000c8
E 80000100 b 00 00 00 0000000000000000
E 80000104 b 00 00 00 0000000000000000
